/* common/issue_pkg.sv */
package issue_pkg;

    // ----------------------------------------
    // Queue sizing
    // ----------------------------------------
    localparam int queue_depth = 8;    // Also the sender's credits after reset
    localparam int queue_ptr_w = 3;

    // ----------------------------------------
    // MIPS encodings
    // ----------------------------------------
    typedef enum logic [5:0] {
        op_special = 6'h00, op_regimm = 6'h01, op_j     = 6'h02, op_jal   = 6'h03,
        op_beq     = 6'h04, op_bne    = 6'h05, op_blez  = 6'h06, op_bgtz  = 6'h07,
        op_addi    = 6'h08, op_addiu  = 6'h09, op_slti  = 6'h0a, op_andi  = 6'h0c,
        op_ori     = 6'h0d, op_xori   = 6'h0e, op_lui   = 6'h0f, op_lb    = 6'h20,
        op_lh      = 6'h21, op_lw     = 6'h23, op_lbu   = 6'h24, op_lhu   = 6'h25,
        op_sb      = 6'h28, op_sh     = 6'h29, op_sw    = 6'h2b
    } mips_opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00, fn_srl   = 6'h02, fn_sra  = 6'h03, fn_jr    = 6'h08,
        fn_jalr = 6'h09, fn_mfhi  = 6'h10, fn_mthi = 6'h11, fn_mflo  = 6'h12,
        fn_mtlo = 6'h13, fn_mult  = 6'h18, fn_multu = 6'h19, fn_div  = 6'h1a,
        fn_divu = 6'h1b, fn_add   = 6'h20, fn_addu = 6'h21, fn_sub   = 6'h22,
        fn_subu = 6'h23, fn_and   = 6'h24, fn_or   = 6'h25, fn_xor   = 6'h26,
        fn_nor  = 6'h27, fn_slt   = 6'h2a, fn_sltu = 6'h2b
    } mips_funct_e;

    // Pairing class
    typedef enum logic [2:0] {
        class_alu,
        class_branch,
        class_jump_imm,
        class_jump_reg,
        class_load_store,
        class_hilo
    } inst_class_e;

    // ----------------------------------------
    // Payloads
    // ----------------------------------------
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_lane_t;

    typedef struct packed {
        fetch_lane_t [1:0] lane;       // Lane 0 is the older one
    } fetch_pair_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } queue_entry_t;

    typedef struct packed {
        logic [31:0]  pc;
        logic [31:0]  inst;
        mips_opcode_e opcode;
        logic [4:0]   rs;
        logic [4:0]   rt;
        logic [4:0]   rd;
        logic [4:0]   sa;
        mips_funct_e  funct;
        logic [15:0]  imme;
        logic [25:0]  j_imme;
        logic         w_reg_ena;
        logic [4:0]   w_reg_dst;
        inst_class_e  inst_class;
    } decoded_inst_t;

    typedef struct packed {
        logic          valid;
        decoded_inst_t inst;
    } issue_slot_t;

endpackage

/* filelist.f */
common/issue_pkg.sv
inst_queue/inst_queue.sv
verilog/pre_decoder.sv
verilog/issue_logic.sv
verilog/issue_top.sv
verif/issue_tb.sv

/* inst_queue/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue (
    input  logic                   clk,
    input  logic                   reset,
    input  issue_pkg::fetch_pair_t push,
    input  logic [1:0]             pop,
    output issue_pkg::queue_entry_t head_0,
    output issue_pkg::queue_entry_t head_1,
    output logic [1:0]             head_ok,
    output logic [1:0]             credit_return
);
    import issue_pkg::*;

    queue_entry_t mem [queue_depth];

    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w:0]   count;

    logic [1:0] push_cnt;
    logic [1:0] pop_cnt;
    queue_entry_t lane_0_entry;
    queue_entry_t lane_1_entry;

    // ----------------------------------------
    // Counts
    // ----------------------------------------
    // Lane 1 is only valid together with lane 0, so the count is a plain sum
    assign push_cnt = {1'b0, push.lane[0].valid} + {1'b0, push.lane[1].valid};
    assign pop_cnt  = {1'b0, pop[0]} + {1'b0, pop[1]};

    assign lane_0_entry.pc   = push.lane[0].pc;
    assign lane_0_entry.inst = push.lane[0].inst;
    assign lane_1_entry.pc   = push.lane[1].pc;
    assign lane_1_entry.inst = push.lane[1].inst;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (push.lane[0].valid) begin
            mem[wr_ptr] <= lane_0_entry;
        end
        if (push.lane[1].valid) begin
            mem[wr_ptr + queue_ptr_w'(1)] <= lane_1_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + queue_ptr_w'(push_cnt);
            rd_ptr <= rd_ptr + queue_ptr_w'(pop_cnt);
            count  <= count + (queue_ptr_w + 1)'(push_cnt) - (queue_ptr_w + 1)'(pop_cnt);
        end
    end

    // ----------------------------------------
    // Head and credits
    // ----------------------------------------
    assign head_0 = mem[rd_ptr];
    assign head_1 = mem[rd_ptr + queue_ptr_w'(1)];   // Wraps with the pointer

    // Occupancy flags come straight from the registered count
    assign head_ok[0] = (count != '0);
    assign head_ok[1] = (count >= (queue_ptr_w + 1)'(2));

    assign credit_return = pop_cnt;   // One credit per entry leaving

endmodule

/* verif/issue_tb.sv */
`timescale 1ns/1ps

module issue_tb;
    import issue_pkg::*;

    localparam int max_insts  = 64;
    localparam int max_groups = 64;
    localparam int max_tests  = 16;
    localparam int wait_limit = 500;

    logic              clk;
    logic              reset;
    logic              stall;
    fetch_pair_t       push;
    logic [1:0]        credit_return;
    issue_slot_t [1:0] issue_out;

    // Vector storage is filled once from the file
    logic [31:0] inst_pc          [max_insts];
    logic [31:0] inst_word        [max_insts];
    logic [31:0] group_pc         [max_groups];
    logic        group_dual       [max_groups];
    logic [31:0] test_stall_mask  [max_tests];
    int          test_inst_first  [max_tests];
    int          test_inst_cnt    [max_tests];
    int          test_group_first [max_tests];
    int          test_group_cnt   [max_tests];
    int          n_tests;
    int          n_insts;
    int          n_groups;

    int          credits;          // Sender side credit counter
    int          errors;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          next_push;
    int          last_push;
    int          group_base;
    int          group_cnt;
    int          groups_seen;
    logic        timed_out;
    logic [31:0] cur_mask;
    logic        held_valid;
    logic [31:0] held_pc;
    logic        held_dual;
    logic [31:0] held_pc_1;

    issue_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .push          (push),
        .credit_return (credit_return),
        .issue_out     (issue_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Vector file
    // ----------------------------------------
    task automatic load_vectors;
        int               fd;
        int               code;
        logic [8*8-1:0]   word;
        logic [8*8-1:0]   kind;
        logic [8*100-1:0] rest;
        logic [31:0]      a;
        logic [31:0]      b;
        fd = $fopen("verif/issue_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/issue_vectors.txt");
            errors++;
        end else begin
            code = $fscanf(fd, "%s", word);
            while (code == 1) begin
                if (word == "#") begin
                    code = $fgets(rest, fd);             // Rest of a comment row
                end else if (word == "test") begin
                    code = $fscanf(fd, "%h", b);
                    test_stall_mask[n_tests]  = b;
                    test_inst_first[n_tests]  = n_insts;
                    test_inst_cnt[n_tests]    = 0;
                    test_group_first[n_tests] = n_groups;
                    test_group_cnt[n_tests]   = 0;
                    n_tests++;
                end else if (word == "inst" && n_tests > 0) begin
                    code = $fscanf(fd, "%h %h", a, b);
                    inst_pc[n_insts]   = a;
                    inst_word[n_insts] = b;
                    n_insts++;
                    test_inst_cnt[n_tests-1]++;
                end else if (word == "group" && n_tests > 0) begin
                    code = $fscanf(fd, "%h %s", a, kind);
                    if (kind != "dual" && kind != "single") begin
                        $display("Group at pc %h is neither single nor dual", a);
                        errors++;
                    end
                    group_pc[n_groups]   = a;
                    group_dual[n_groups] = (kind == "dual");
                    n_groups++;
                    test_group_cnt[n_tests-1]++;
                end else begin
                    $display("Unknown row in the vector file");
                    errors++;
                end
                code = $fscanf(fd, "%s", word);
            end
            $fclose(fd);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
        test_errors++;
    endtask

    // ----------------------------------------
    // Per cycle sampling and driving
    // ----------------------------------------
    task automatic collect_issue;
        int          idx;
        logic [31:0] exp_pc;
        if (stall) begin
            // The group loaded before the stalled edge must still be there
            if (issue_out[0].valid !== held_valid) begin
                report_mismatch("issue_out[0].valid (held)", held_valid, issue_out[0].valid);
            end else if (held_valid && issue_out[0].inst.pc !== held_pc) begin
                report_mismatch("issue_out[0].pc (held)", held_pc, issue_out[0].inst.pc);
            end
            if (issue_out[1].valid !== held_dual) begin
                report_mismatch("issue_out[1].valid (held)", held_dual, issue_out[1].valid);
            end else if (held_dual && issue_out[1].inst.pc !== held_pc_1) begin
                report_mismatch("issue_out[1].pc (held)", held_pc_1, issue_out[1].inst.pc);
            end
        end else if (issue_out[0].valid) begin
            idx    = group_base + groups_seen;
            exp_pc = group_pc[idx];
            if (issue_out[0].inst.pc !== exp_pc) begin
                report_mismatch("issue_out[0].pc", exp_pc, issue_out[0].inst.pc);
            end
            if (issue_out[1].valid !== group_dual[idx]) begin
                report_mismatch("issue_out[1].valid", group_dual[idx], issue_out[1].valid);
            end
            if (group_dual[idx] && issue_out[1].inst.pc !== exp_pc + 32'd4) begin
                report_mismatch("issue_out[1].pc", exp_pc + 32'd4, issue_out[1].inst.pc);
            end
            groups_seen++;
        end
        held_valid = issue_out[0].valid;
        held_pc    = issue_out[0].inst.pc;
        held_dual  = issue_out[1].valid;
        held_pc_1  = issue_out[1].inst.pc;
    endtask

    task automatic step_cycle(input int cyc);
        int lanes;
        @(negedge clk);
        collect_issue();
        stall = (cyc < 32) ? cur_mask[cyc] : 1'b0;
        push  = '0;
        lanes = 0;
        while (lanes < 2 && next_push < last_push && credits > 0) begin
            push.lane[lanes].valid = 1'b1;
            push.lane[lanes].pc    = inst_pc[next_push];
            push.lane[lanes].inst  = inst_word[next_push];
            lanes++;
            next_push++;
            credits--;
        end
        #1;
        credits += credit_return;   // Entries popped at the coming edge
    endtask

    task automatic run_test(input int t);
        int cyc;
        cur_mask    = test_stall_mask[t];
        next_push   = test_inst_first[t];
        last_push   = next_push + test_inst_cnt[t];
        group_base  = test_group_first[t];
        group_cnt   = test_group_cnt[t];
        groups_seen = 0;
        test_errors = 0;
        cyc         = 0;
        while (groups_seen < group_cnt && cyc < wait_limit) begin
            step_cycle(cyc);
            cyc++;
        end
        if (groups_seen < group_cnt) begin
            $display("Test %0d timed out with %0d of %0d groups issued",
                     t, groups_seen, group_cnt);
            timed_out = 1'b1;
        end
        if (test_errors == 0 && !timed_out) begin
            $display("Test %0d passed, %0d groups in %0d cycles", t, group_cnt, cyc);
            tests_passed++;
        end else begin
            $display("Test %0d failed with %0d errors", t, test_errors);
            tests_failed++;
        end
        errors += test_errors;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int t;
        reset        = 1'b1;
        stall        = 1'b0;
        push         = '0;
        credits      = queue_depth;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        n_tests      = 0;
        n_insts      = 0;
        n_groups     = 0;
        timed_out    = 1'b0;
        held_valid   = 1'b0;
        held_pc      = '0;
        held_dual    = 1'b0;
        held_pc_1    = '0;
        load_vectors();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        t = 0;
        while (t < n_tests && !timed_out) begin
            run_test(t);
            t++;
        end
        if (credits != queue_depth) begin
            $display("FAIL %0t credits expected %0d got %0d", $time, queue_depth, credits);
            errors++;
        end
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && !timed_out && n_tests > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verif/issue_vectors.txt */
# Rows: test <stall mask, bit n stalls cycle n> / inst <pc> <word>
# group <slot 0 pc> <single or dual>, listed in issue order
# Independent ALU pairs
test 00000000
inst 00400000 00221821
inst 00400004 00853021
inst 00400008 00E84821
inst 0040000c 014B6021
group 00400000 dual
group 00400008 dual
# RAW from slot 1 to slot 2, odd tail
test 00000000
inst 00400100 00221821
inst 00400104 00652021
inst 00400108 01093821
inst 0040010c 016C5021
group 00400100 single
group 00400104 dual
group 0040010c single
# Same sequence through register 0
test 00000000
inst 00400200 00220021
inst 00400204 00052021
inst 00400208 01093821
inst 0040020c 016C5021
group 00400200 dual
group 00400208 dual
# Load and HI/LO in slot 1
test 00000000
inst 00400300 8C220000
inst 00400304 00E80018
inst 00400308 014B6021
inst 0040030c AC230004
group 00400300 single
group 00400304 single
group 00400308 dual
# Branch, j and jr with delay slots
test 00000000
inst 00400400 10220004
inst 00400404 00221821
inst 00400408 00853021
inst 0040040c 08100040
inst 00400410 00E84821
inst 00400414 03E00008
inst 00400418 014B6021
group 00400400 dual
group 00400408 single
group 0040040c dual
group 00400414 dual
# Stalls fill the queue and use up all credits
test 0000027E
inst 00400500 00221821
inst 00400504 00853021
inst 00400508 00E84821
inst 0040050c 014B6021
inst 00400510 00221821
inst 00400514 00853021
inst 00400518 00E84821
inst 0040051c 014B6021
inst 00400520 00221821
group 00400500 dual
group 00400508 dual
group 00400510 dual
group 00400518 dual
group 00400520 single

/* verilog/issue_logic.sv */
`timescale 1ns/1ps

module issue_logic (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic [1:0]                    head_ok,
    input  issue_pkg::decoded_inst_t      slot_0,
    input  issue_pkg::decoded_inst_t      slot_1,
    output logic [1:0]                    pop,
    output issue_pkg::issue_slot_t [1:0]  issue_out
);
    import issue_pkg::*;

    logic jmp_0;
    logic jmp_1;
    logic ls_0;
    logic hilo_0;
    logic raw_conflict;
    logic pair;

    logic [1:0]          valid_q;
    decoded_inst_t [1:0] inst_q;

    // ----------------------------------------
    // Pairing checks
    // ----------------------------------------
    assign jmp_0 = (slot_0.inst_class == class_branch) ||
                   (slot_0.inst_class == class_jump_imm) ||
                   (slot_0.inst_class == class_jump_reg);
    assign jmp_1 = (slot_1.inst_class == class_branch) ||
                   (slot_1.inst_class == class_jump_imm) ||
                   (slot_1.inst_class == class_jump_reg);
    assign ls_0   = (slot_0.inst_class == class_load_store);
    assign hilo_0 = (slot_0.inst_class == class_hilo);

    // Writes to register 0 never create a dependence
    assign raw_conflict = slot_0.w_reg_ena &&
        (((slot_0.w_reg_dst == slot_1.rs) && (slot_1.rs != 5'd0)) ||
         ((slot_0.w_reg_dst == slot_1.rt) && (slot_1.rt != 5'd0)));

    always_comb begin
        pair = 1'b0;
        if (jmp_0) begin
            pair = 1'b1;                 // Keep the delay slot with its jump
        end else if (raw_conflict) begin
            pair = 1'b0;
        end else if (ls_0) begin
            pair = 1'b0;
        end else if (jmp_1) begin
            pair = 1'b0;                 // Wait so it pairs with its own delay slot
        end else if (hilo_0) begin
            pair = 1'b0;
        end else begin
            pair = 1'b1;
        end
    end

    // Slot 1 only leaves when it really exists
    assign pop[0] = !stall && head_ok[0];
    assign pop[1] = !stall && head_ok[0] && head_ok[1] && pair;

    // ----------------------------------------
    // Issue register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 2'b00;
        end else if (!stall) begin
            valid_q <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop[0]) inst_q[0] <= slot_0;
        if (pop[1]) inst_q[1] <= slot_1;
    end

    assign issue_out[0].valid = valid_q[0];
    assign issue_out[0].inst  = inst_q[0];
    assign issue_out[1].valid = valid_q[1];
    assign issue_out[1].inst  = inst_q[1];

endmodule

/* verilog/issue_top.sv */
`timescale 1ns/1ps

module issue_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall,
    input  issue_pkg::fetch_pair_t       push,
    output logic [1:0]                   credit_return,
    output issue_pkg::issue_slot_t [1:0] issue_out
);
    import issue_pkg::*;

    queue_entry_t  head_0;
    queue_entry_t  head_1;
    logic [1:0]    head_ok;
    logic [1:0]    pop;
    decoded_inst_t dec_0;
    decoded_inst_t dec_1;

    // ----------------------------------------
    // Queue and pre-decode
    // ----------------------------------------
    inst_queue queue_i (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .pop           (pop),
        .head_0        (head_0),
        .head_1        (head_1),
        .head_ok       (head_ok),
        .credit_return (credit_return)
    );

    pre_decoder dec_0_i (.entry(head_0), .decoded(dec_0));   // Older entry
    pre_decoder dec_1_i (.entry(head_1), .decoded(dec_1));

    // ----------------------------------------
    // Pairing and issue register
    // ----------------------------------------
    issue_logic issue_i (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .head_ok   (head_ok),
        .slot_0    (dec_0),
        .slot_1    (dec_1),
        .pop       (pop),
        .issue_out (issue_out)
    );

endmodule

/* verilog/pre_decoder.sv */
`timescale 1ns/1ps

module pre_decoder (
    input  issue_pkg::queue_entry_t  entry,
    output issue_pkg::decoded_inst_t decoded
);
    import issue_pkg::*;

    mips_opcode_e op;
    mips_funct_e  fn;
    logic [4:0]   rs;
    logic [4:0]   rt;
    logic [4:0]   rd;
    logic         w_ena;
    logic [4:0]   w_dst;
    inst_class_e  cls;

    // ----------------------------------------
    // Field split
    // ----------------------------------------
    assign op = mips_opcode_e'(entry.inst[31:26]);
    assign fn = mips_funct_e'(entry.inst[5:0]);
    assign rs = entry.inst[25:21];
    assign rt = entry.inst[20:16];
    assign rd = entry.inst[15:11];

    // ----------------------------------------
    // Write target and class
    // ----------------------------------------
    always_comb begin
        w_ena = 1'b0;
        w_dst = 5'd0;
        cls   = class_alu;
        case (op)
            op_special: begin
                w_ena = 1'b1;
                w_dst = rd;
                case (fn)
                    fn_jr: begin
                        w_ena = 1'b0;
                        cls   = class_jump_reg;
                    end
                    fn_jalr: begin
                        cls = class_jump_reg;   // Link goes to rd
                    end
                    fn_mfhi, fn_mflo: begin
                        cls = class_hilo;
                    end
                    fn_mthi, fn_mtlo, fn_mult, fn_multu, fn_div, fn_divu: begin
                        w_ena = 1'b0;           // Only HI/LO change
                        cls   = class_hilo;
                    end
                    default: begin
                        cls = class_alu;
                    end
                endcase
            end
            op_regimm, op_beq, op_bne, op_blez, op_bgtz: begin
                cls = class_branch;
            end
            op_j: begin
                cls = class_jump_imm;
            end
            op_jal: begin
                w_ena = 1'b1;
                w_dst = 5'd31;
                cls   = class_jump_imm;
            end
            op_addi, op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui: begin
                w_ena = 1'b1;
                w_dst = rt;
            end
            op_lb, op_lh, op_lw, op_lbu, op_lhu: begin
                w_ena = 1'b1;
                w_dst = rt;
                cls   = class_load_store;
            end
            op_sb, op_sh, op_sw: begin
                cls = class_load_store;
            end
            default: begin
                cls = class_alu;   // Unknown opcodes pair freely and write nothing
            end
        endcase
    end

    assign decoded.pc         = entry.pc;
    assign decoded.inst       = entry.inst;
    assign decoded.opcode     = op;
    assign decoded.rs         = rs;
    assign decoded.rt         = rt;
    assign decoded.rd         = rd;
    assign decoded.sa         = entry.inst[10:6];
    assign decoded.funct      = fn;
    assign decoded.imme       = entry.inst[15:0];
    assign decoded.j_imme     = entry.inst[25:0];
    assign decoded.w_reg_ena  = w_ena;
    assign decoded.w_reg_dst  = w_dst;
    assign decoded.inst_class = cls;

endmodule
